// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - files:
      - hw/core_pkg.sv
      - hw/pipe_reg.sv
      - hw/fetch_stage.sv
      - hw/decoder.sv
      - hw/regfile.sv
      - hw/exe_stage.sv
      - hw/csr_unit.sv
      - hw/control_unit.sv
      - hw/datapath.sv
  - target: test
    files:
      - verif/tb_datapath.sv

// ==== compile.f ====
hw/core_pkg.sv
hw/pipe_reg.sv
hw/fetch_stage.sv
hw/decoder.sv
hw/regfile.sv
hw/exe_stage.sv
hw/csr_unit.sv
hw/control_unit.sv
hw/datapath.sv
verif/tb_datapath.sv

// ==== hw/control_unit.sv ====
module control_unit (
    input  logic                      branch_taken_i,
    input  logic [core_pkg::XLEN-1:0] branch_target_i,
    input  logic                      wb_xcpt_i,
    input  logic                      wb_mret_i,
    input  logic [core_pkg::XLEN-1:0] evec_i,
    input  logic                      wb_valid_i,
    input  logic                      wb_reg_we_i,
    output logic                      redirect_o,
    output logic [core_pkg::XLEN-1:0] redirect_pc_o,
    output logic                      flush_id_o,
    output logic                      flush_ex_o,
    output logic                      flush_wb_o,
    output logic                      rf_we_o
);

    logic trap;

    // Trap or MRET in WB overrides any branch in EX
    assign trap = wb_valid_i && (wb_xcpt_i || wb_mret_i);

    assign redirect_o    = trap || branch_taken_i;
    assign redirect_pc_o = trap ? evec_i : branch_target_i;

    // Kill younger instructions; a trap also stops EX entering WB
    assign flush_id_o = redirect_o;
    assign flush_ex_o = redirect_o;
    assign flush_wb_o = trap;

    assign rf_we_o = wb_valid_i && wb_reg_we_i && !wb_xcpt_i;

endmodule

// ==== hw/core_pkg.sv ====
package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 12;

    // RV32I major opcodes used by this core
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // Full encodings of the system instructions
    localparam logic [31:0] INSTR_ECALL = 32'h0000_0073;
    localparam logic [31:0] INSTR_MRET  = 32'h3020_0073;

    typedef enum logic [3:0] {
        OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LUI, OP_BEQ,
        OP_BNE, OP_JAL, OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_ECALL, OP_MRET, OP_ILLEGAL
    } op_e;

    typedef enum logic [2:0] {
        CSR_CMD_NONE, CSR_CMD_WRITE, CSR_CMD_SET, CSR_CMD_CLEAR, CSR_CMD_READ, CSR_CMD_SYS
    } csr_cmd_e;

    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET = 12'hB02;

    localparam logic [XLEN-1:0] CAUSE_ILLEGAL = 32'd2;
    localparam logic [XLEN-1:0] CAUSE_ECALL   = 32'd11;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        logic [CSR_ADDR_W-1:0] csr_addr;
        logic                  illegal;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_we;
        logic [XLEN-1:0]       result;
        logic [REG_ADDR_W-1:0] rs1;
        logic [CSR_ADDR_W-1:0] csr_addr;
        logic                  xcpt;
        logic [XLEN-1:0]       xcpt_cause;
    } ex_wb_t;

endpackage

// ==== hw/csr_unit.sv ====
module csr_unit (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  core_pkg::csr_cmd_e              cmd_i,
    input  logic [core_pkg::CSR_ADDR_W-1:0] addr_i,
    input  logic [core_pkg::XLEN-1:0]       wdata_i,
    input  logic                            retire_i,
    input  logic                            xcpt_i,
    input  logic [core_pkg::XLEN-1:0]       xcpt_cause_i,
    input  logic [core_pkg::XLEN-1:0]       xcpt_pc_i,
    input  logic                            mret_i,
    output logic [core_pkg::XLEN-1:0]       rdata_o,
    output logic [core_pkg::XLEN-1:0]       evec_o
);

    logic [core_pkg::XLEN-1:0] mscratch_q, mepc_q, mcause_q, mtvec_q, minstret_q;
    logic [core_pkg::XLEN-1:0] wval;
    logic                      wen;

    always_comb begin
        case (addr_i)
            core_pkg::CSR_MSCRATCH: rdata_o = mscratch_q;
            core_pkg::CSR_MEPC:     rdata_o = mepc_q;
            core_pkg::CSR_MCAUSE:   rdata_o = mcause_q;
            core_pkg::CSR_MTVEC:    rdata_o = mtvec_q;
            core_pkg::CSR_MINSTRET: rdata_o = minstret_q;
            default:                rdata_o = '0;
        endcase
    end

    // Read-modify-write on the old value
    always_comb begin
        wen  = 1'b1;
        wval = wdata_i;
        case (cmd_i)
            core_pkg::CSR_CMD_WRITE: wval = wdata_i;
            core_pkg::CSR_CMD_SET:   wval = rdata_o | wdata_i;
            core_pkg::CSR_CMD_CLEAR: wval = rdata_o & ~wdata_i;
            default:                 wen  = 1'b0;
        endcase
    end

    assign evec_o = mret_i ? mepc_q : mtvec_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtvec_q    <= '0;
            minstret_q <= '0;
        end else begin
            if (retire_i) minstret_q <= minstret_q + 32'd1;
            if (xcpt_i) begin
                mepc_q   <= xcpt_pc_i;
                mcause_q <= xcpt_cause_i;
            end
            // An explicit write overrides the retire count
            if (wen) begin
                case (addr_i)
                    core_pkg::CSR_MSCRATCH: mscratch_q <= wval;
                    core_pkg::CSR_MEPC:     mepc_q     <= wval;
                    core_pkg::CSR_MCAUSE:   mcause_q   <= wval;
                    core_pkg::CSR_MTVEC:    mtvec_q    <= wval;
                    core_pkg::CSR_MINSTRET: minstret_q <= wval;
                    default: ;
                endcase
            end
        end
    end

    a_trap_excl: assert property (@(posedge clk_i) disable iff (!rstn_i) !(xcpt_i && mret_i));

endmodule

// ==== hw/datapath.sv ====
module datapath #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = 32'h0000_0000
) (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic [core_pkg::XLEN-1:0]       wb_dat_i,
    input  logic                            wb_ack_i,
    output logic                            wb_cyc_o,
    output logic                            wb_stb_o,
    output logic [core_pkg::XLEN-1:0]       wb_adr_o,
    output logic                            commit_valid_o,
    output logic [core_pkg::XLEN-1:0]       commit_pc_o,
    output logic                            commit_we_o,
    output logic [core_pkg::REG_ADDR_W-1:0] commit_rd_o,
    output logic [core_pkg::XLEN-1:0]       commit_data_o,
    output logic                            commit_xcpt_o
);

    core_pkg::if_id_t          if_d, if_q;
    core_pkg::id_ex_t          id_dec, id_d, id_q;
    core_pkg::ex_wb_t          ex_d, wb_q;
    core_pkg::csr_cmd_e        csr_cmd;
    logic [core_pkg::XLEN-1:0] rs1_data, rs2_data, branch_target, redirect_pc;
    logic [core_pkg::XLEN-1:0] evec, csr_rdata, wb_data;
    logic                      branch_taken, redirect, flush_id, flush_ex, flush_wb, rf_we;
    logic                      wb_xcpt, wb_mret, wb_is_csr;

    fetch_stage #(.RESET_PC(RESET_PC)) fetch_inst (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i),
        .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_adr_o(wb_adr_o),
        .fetch_o(if_d)
    );

    pipe_reg #(.payload_t(core_pkg::if_id_t)) if_id_reg (
        .clk_i(clk_i), .rstn_i(rstn_i), .load_i(1'b1), .flush_i(flush_id),
        .d_i(if_d), .q_o(if_q)
    );

    // ID: decode and register read
    decoder decoder_inst (.instr_i(if_q), .decoded_o(id_dec));

    regfile regfile_inst (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .we_i(rf_we), .waddr_i(wb_q.rd), .wdata_i(wb_data),
        .raddr1_i(id_dec.rs1), .raddr2_i(id_dec.rs2),
        .rdata1_o(rs1_data), .rdata2_o(rs2_data)
    );

    always_comb begin
        id_d          = id_dec;
        id_d.rs1_data = rs1_data;
        id_d.rs2_data = rs2_data;
    end

    pipe_reg #(.payload_t(core_pkg::id_ex_t)) id_ex_reg (
        .clk_i(clk_i), .rstn_i(rstn_i), .load_i(1'b1), .flush_i(flush_ex),
        .d_i(id_d), .q_o(id_q)
    );

    exe_stage exe_inst (
        .from_id_i(id_q),
        .byp_valid_i(rf_we), .byp_rd_i(wb_q.rd), .byp_data_i(wb_data),
        .to_wb_o(ex_d), .branch_taken_o(branch_taken), .branch_target_o(branch_target)
    );

    pipe_reg #(.payload_t(core_pkg::ex_wb_t)) ex_wb_reg (
        .clk_i(clk_i), .rstn_i(rstn_i), .load_i(1'b1), .flush_i(flush_wb),
        .d_i(ex_d), .q_o(wb_q)
    );

    // WB: CSR command from the retiring instruction
    assign wb_xcpt = wb_q.valid && wb_q.xcpt;
    assign wb_mret = wb_q.valid && wb_q.op == core_pkg::OP_MRET;

    always_comb begin
        csr_cmd   = core_pkg::CSR_CMD_NONE;
        wb_is_csr = 1'b0;
        if (wb_q.valid) begin
            case (wb_q.op)
                core_pkg::OP_CSRRW: begin
                    csr_cmd   = core_pkg::CSR_CMD_WRITE;
                    wb_is_csr = 1'b1;
                end
                core_pkg::OP_CSRRS: begin
                    csr_cmd   = (wb_q.rs1 == '0) ? core_pkg::CSR_CMD_READ : core_pkg::CSR_CMD_SET;
                    wb_is_csr = 1'b1;
                end
                core_pkg::OP_CSRRC: begin
                    csr_cmd   = (wb_q.rs1 == '0) ? core_pkg::CSR_CMD_READ : core_pkg::CSR_CMD_CLEAR;
                    wb_is_csr = 1'b1;
                end
                core_pkg::OP_ECALL, core_pkg::OP_MRET: csr_cmd = core_pkg::CSR_CMD_SYS;
                default: csr_cmd = core_pkg::CSR_CMD_NONE;
            endcase
        end
    end

    csr_unit csr_inst (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .cmd_i(csr_cmd), .addr_i(wb_q.csr_addr), .wdata_i(wb_q.result),
        .retire_i(wb_q.valid && !wb_q.xcpt),
        .xcpt_i(wb_xcpt), .xcpt_cause_i(wb_q.xcpt_cause), .xcpt_pc_i(wb_q.pc),
        .mret_i(wb_mret), .rdata_o(csr_rdata), .evec_o(evec)
    );

    control_unit control_inst (
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .wb_xcpt_i(wb_xcpt), .wb_mret_i(wb_mret), .evec_i(evec),
        .wb_valid_i(wb_q.valid), .wb_reg_we_i(wb_q.reg_we),
        .redirect_o(redirect), .redirect_pc_o(redirect_pc),
        .flush_id_o(flush_id), .flush_ex_o(flush_ex), .flush_wb_o(flush_wb),
        .rf_we_o(rf_we)
    );

    // Old CSR value goes to rd for CSR ops
    assign wb_data = wb_is_csr ? csr_rdata : wb_q.result;

    // Commit trace
    assign commit_valid_o = wb_q.valid;
    assign commit_pc_o    = wb_q.pc;
    assign commit_we_o    = rf_we;
    assign commit_rd_o    = wb_q.rd;
    assign commit_data_o  = wb_data;
    assign commit_xcpt_o  = wb_xcpt;

endmodule

// ==== hw/decoder.sv ====
module decoder (
    input  core_pkg::if_id_t instr_i,
    output core_pkg::id_ex_t decoded_o
);

    logic [31:0]               instr;
    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [core_pkg::XLEN-1:0] imm_i;
    logic [core_pkg::XLEN-1:0] imm_u;
    logic [core_pkg::XLEN-1:0] imm_b;
    logic [core_pkg::XLEN-1:0] imm_j;

    assign instr  = instr_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        decoded_o          = '0;
        decoded_o.valid    = instr_i.valid;
        decoded_o.pc       = instr_i.pc;
        decoded_o.rd       = instr[11:7];
        decoded_o.rs1      = instr[19:15];
        decoded_o.rs2      = instr[24:20];
        decoded_o.csr_addr = instr[31:20];
        decoded_o.imm      = imm_i;
        decoded_o.op       = core_pkg::OP_ILLEGAL;
        case (opcode)
            core_pkg::OPC_OP_IMM: begin
                if (funct3 == 3'b000) decoded_o.op = core_pkg::OP_ADDI;
            end
            core_pkg::OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  decoded_o.op = core_pkg::OP_ADD;
                        3'b100:  decoded_o.op = core_pkg::OP_XOR;
                        3'b110:  decoded_o.op = core_pkg::OP_OR;
                        3'b111:  decoded_o.op = core_pkg::OP_AND;
                        default: decoded_o.op = core_pkg::OP_ILLEGAL;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    decoded_o.op = core_pkg::OP_SUB;
                end
            end
            core_pkg::OPC_LUI: begin
                decoded_o.op  = core_pkg::OP_LUI;
                decoded_o.imm = imm_u;
            end
            core_pkg::OPC_BRANCH: begin
                decoded_o.imm = imm_b;
                if (funct3 == 3'b000) decoded_o.op = core_pkg::OP_BEQ;
                else if (funct3 == 3'b001) decoded_o.op = core_pkg::OP_BNE;
            end
            core_pkg::OPC_JAL: begin
                decoded_o.op  = core_pkg::OP_JAL;
                decoded_o.imm = imm_j;
            end
            core_pkg::OPC_SYSTEM: begin
                case (funct3)
                    3'b001: decoded_o.op = core_pkg::OP_CSRRW;
                    3'b010: decoded_o.op = core_pkg::OP_CSRRS;
                    3'b011: decoded_o.op = core_pkg::OP_CSRRC;
                    3'b000: begin
                        // Only exact ECALL and MRET words are accepted
                        if (instr == core_pkg::INSTR_ECALL) decoded_o.op = core_pkg::OP_ECALL;
                        else if (instr == core_pkg::INSTR_MRET) decoded_o.op = core_pkg::OP_MRET;
                    end
                    default: decoded_o.op = core_pkg::OP_ILLEGAL;
                endcase
            end
            default: decoded_o.op = core_pkg::OP_ILLEGAL;
        endcase
        decoded_o.illegal = (decoded_o.op == core_pkg::OP_ILLEGAL);
    end

endmodule

// ==== hw/exe_stage.sv ====
module exe_stage (
    input  core_pkg::id_ex_t                from_id_i,
    input  logic                            byp_valid_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] byp_rd_i,
    input  logic [core_pkg::XLEN-1:0]       byp_data_i,
    output core_pkg::ex_wb_t                to_wb_o,
    output logic                            branch_taken_o,
    output logic [core_pkg::XLEN-1:0]       branch_target_o
);

    logic [core_pkg::XLEN-1:0] op_a;
    logic [core_pkg::XLEN-1:0] op_b;
    logic [core_pkg::XLEN-1:0] result;
    logic                      writes_rd;
    logic                      take;

    // WB bypass; byp_valid_i already excludes x0
    assign op_a = (byp_valid_i && byp_rd_i == from_id_i.rs1) ? byp_data_i : from_id_i.rs1_data;
    assign op_b = (byp_valid_i && byp_rd_i == from_id_i.rs2) ? byp_data_i : from_id_i.rs2_data;

    always_comb begin
        result    = '0;
        writes_rd = 1'b1;
        case (from_id_i.op)
            core_pkg::OP_ADDI: result = op_a + from_id_i.imm;
            core_pkg::OP_ADD:  result = op_a + op_b;
            core_pkg::OP_SUB:  result = op_a - op_b;
            core_pkg::OP_AND:  result = op_a & op_b;
            core_pkg::OP_OR:   result = op_a | op_b;
            core_pkg::OP_XOR:  result = op_a ^ op_b;
            core_pkg::OP_LUI:  result = from_id_i.imm;
            core_pkg::OP_JAL:  result = from_id_i.pc + 32'd4;
            // CSR ops carry rs1 as the write operand into WB
            core_pkg::OP_CSRRW, core_pkg::OP_CSRRS, core_pkg::OP_CSRRC: result = op_a;
            default: writes_rd = 1'b0;
        endcase
    end

    assign take = (from_id_i.op == core_pkg::OP_BEQ && op_a == op_b) ||
                  (from_id_i.op == core_pkg::OP_BNE && op_a != op_b) ||
                  (from_id_i.op == core_pkg::OP_JAL);

    assign branch_taken_o  = from_id_i.valid && take;
    assign branch_target_o = from_id_i.pc + from_id_i.imm;

    always_comb begin
        to_wb_o            = '0;
        to_wb_o.valid      = from_id_i.valid;
        to_wb_o.pc         = from_id_i.pc;
        to_wb_o.op         = from_id_i.op;
        to_wb_o.rd         = from_id_i.rd;
        to_wb_o.reg_we     = writes_rd && from_id_i.rd != '0;
        to_wb_o.result     = result;
        to_wb_o.rs1        = from_id_i.rs1;
        to_wb_o.csr_addr   = from_id_i.csr_addr;
        to_wb_o.xcpt       = from_id_i.illegal || from_id_i.op == core_pkg::OP_ECALL;
        to_wb_o.xcpt_cause = from_id_i.illegal ? core_pkg::CAUSE_ILLEGAL : core_pkg::CAUSE_ECALL;
    end

endmodule

// ==== hw/fetch_stage.sv ====
module fetch_stage #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = 32'h0000_0000
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      redirect_i,
    input  logic [core_pkg::XLEN-1:0] redirect_pc_i,
    input  logic [core_pkg::XLEN-1:0] wb_dat_i,
    input  logic                      wb_ack_i,
    output logic                      wb_cyc_o,
    output logic                      wb_stb_o,
    output logic [core_pkg::XLEN-1:0] wb_adr_o,
    output core_pkg::if_id_t          fetch_o
);

    logic [core_pkg::XLEN-1:0] pc_q;
    logic [core_pkg::XLEN-1:0] adr_q;
    logic [core_pkg::XLEN-1:0] start_pc;
    logic                      cyc_q;
    logic                      discard_q;

    // A redirect seen while idle goes straight onto the bus
    assign start_pc = redirect_i ? redirect_pc_i : pc_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cyc_q     <= 1'b0;
            discard_q <= 1'b0;
            pc_q      <= RESET_PC;
            adr_q     <= RESET_PC;
        end else if (!cyc_q) begin
            cyc_q <= 1'b1;
            adr_q <= start_pc;
            pc_q  <= start_pc;
        end else if (wb_ack_i) begin
            // Bus goes idle for one cycle between transfers
            cyc_q     <= 1'b0;
            discard_q <= 1'b0;
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (!discard_q) begin
                pc_q <= pc_q + 32'd4;
            end
        end else if (redirect_i) begin
            // Target waits in pc_q and the stale data is dropped on ack
            discard_q <= 1'b1;
            pc_q      <= redirect_pc_i;
        end
    end

    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = cyc_q;
    assign wb_adr_o = adr_q;

    always_comb begin
        fetch_o       = '0;
        fetch_o.valid = cyc_q && wb_ack_i && !discard_q;
        fetch_o.pc    = adr_q;
        fetch_o.instr = wb_dat_i;
    end

    a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_ack_i |-> wb_cyc_o);

endmodule

// ==== hw/pipe_reg.sv ====
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     load_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // Flush wins over load so a killed slot becomes a bubble
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;
        end else if (load_i) begin
            q_o <= d_i;
        end
    end

    a_ctrl_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !$isunknown({load_i, flush_i}));

endmodule

// ==== hw/regfile.sv ====
module regfile (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [core_pkg::XLEN-1:0]       wdata_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [core_pkg::XLEN-1:0]       rdata1_o,
    output logic [core_pkg::XLEN-1:0]       rdata2_o
);

    logic [core_pkg::XLEN-1:0] regs_q [32];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < 32; i++) regs_q[i] <= '0;
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Same-cycle WB write is visible to the ID read
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (we_i && waddr_i == raddr1_i) ? wdata_i : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (we_i && waddr_i == raddr2_i) ? wdata_i : regs_q[raddr2_i];

endmodule

// ==== verif/program_stimulus.txt ====
// Program image: hex instruction words, word index = byte address / 4
// Records from @40: test pc we rd data xcpt, a pc of ffffffff ends the list
@00
00500093 00308113 002081b3 40118233  // 00: addi, addi, add, sub
0011f2b3 0020e333 0011c3b3 12345437  // 10: and, or, xor, lui
fff40413 00410463 00100493 00109463  // 20: addi -1, beq taken, skipped, bne
00208463 00209463 00200493 0080056f  // 30: beq, bne taken, skipped, jal x10
00300493 08000593 30559073 34019673  // 40: skipped, addi, csrrw mtvec, csrrw mscratch
340526f3 3401b773 340027f3 b0202873  // 50: csrrs, csrrc, csrrs read, read minstret
00000073 00000000 0000006f           // 60: ecall, illegal word, jal x0 to itself
@20
34202973 341029f3 00498993 34199073 30200073  // 80: handler, mepc += 4, mret
@40
1 00000000 1 01 00000005 0
1 00000004 1 02 00000008 0
1 00000008 1 03 0000000d 0
1 0000000c 1 04 00000008 0
1 00000010 1 05 00000005 0
1 00000014 1 06 0000000d 0
1 00000018 1 07 00000008 0
1 0000001c 1 08 12345000 0
1 00000020 1 08 12344fff 0
2 00000024 0 00 00000000 0
2 0000002c 0 00 00000000 0
2 00000030 0 00 00000000 0
2 00000034 0 00 00000000 0
2 0000003c 1 0a 00000040 0
3 00000044 1 0b 00000080 0
3 00000048 0 00 00000000 0
3 0000004c 1 0c 00000000 0
3 00000050 1 0d 0000000d 0
3 00000054 1 0e 0000004d 0
3 00000058 1 0f 00000040 0
3 0000005c 1 10 00000014 0
4 00000060 0 00 00000000 1
4 00000080 1 12 0000000b 0
4 00000084 1 13 00000060 0
4 00000088 1 13 00000064 0
4 0000008c 0 00 00000000 0
4 00000090 0 00 00000000 0
4 00000064 0 00 00000000 1
4 00000080 1 12 00000002 0
4 00000084 1 13 00000064 0
4 00000088 1 13 00000068 0
4 0000008c 0 00 00000000 0
4 00000090 0 00 00000000 0
4 00000068 0 00 00000000 0
0 ffffffff 0 00 00000000 0

// ==== verif/tb_datapath.sv ====
module tb_datapath;

    localparam logic [31:0] RESET_PC       = 32'h0000_0000;
    localparam int          MEM_WORDS      = 512;
    localparam int          PROG_WORDS     = 64;
    localparam int          REC_BASE       = 64;
    localparam int          REC_WORDS      = 6;
    localparam int          COMMIT_TIMEOUT = 100;
    localparam int          LATENCY_TEST   = 5;
    localparam logic [31:0] END_PC         = 32'hFFFF_FFFF;

    logic        clk_i;
    logic        rstn_i;
    logic [31:0] wb_dat_i;
    logic        wb_ack_i;
    logic        wb_cyc_o;
    logic        wb_stb_o;
    logic [31:0] wb_adr_o;
    logic        commit_valid_o;
    logic [31:0] commit_pc_o;
    logic        commit_we_o;
    logic [4:0]  commit_rd_o;
    logic [31:0] commit_data_o;
    logic        commit_xcpt_o;

    // Program image below REC_BASE and commit records above it
    logic [31:0] stim_mem [MEM_WORDS];
    int          test_checks [6];
    int          test_errors [6];
    integer      seed;
    logic        bus_busy;
    logic        first_req;
    logic [31:0] req_adr;
    int          wait_left;

    datapath #(.RESET_PC(RESET_PC)) uut (
        .clk_i(clk_i),
        .rstn_i(rstn_i),
        .wb_dat_i(wb_dat_i),
        .wb_ack_i(wb_ack_i),
        .wb_cyc_o(wb_cyc_o),
        .wb_stb_o(wb_stb_o),
        .wb_adr_o(wb_adr_o),
        .commit_valid_o(commit_valid_o),
        .commit_pc_o(commit_pc_o),
        .commit_we_o(commit_we_o),
        .commit_rd_o(commit_rd_o),
        .commit_data_o(commit_data_o),
        .commit_xcpt_o(commit_xcpt_o)
    );

    always #4 clk_i = ~clk_i;

    function automatic string test_label(input int id);
        case (id)
            1:       return "alu_chain";
            2:       return "control_flow";
            3:       return "csr_access";
            4:       return "traps";
            5:       return "fetch_latency";
            default: return "unknown";
        endcase
    endfunction

    // Low bits 00 never form a valid RV32I opcode
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[31:2] ^ 30'h1555_5555, 2'b00};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (addr[31:2] < PROG_WORDS) begin
            return stim_mem[addr[31:2]];
        end
        return fill_word(addr);
    endfunction

    task automatic check_value(input int test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        test_checks[test]++;
        if (actual !== expected) begin
            test_errors[test]++;
            $display("FAIL %s %s: expected %h, actual %h",
                     test_label(test), field, expected, actual);
        end
    endtask

    task automatic wait_commit(output logic found);
        int cycles;
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < COMMIT_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
            if (commit_valid_o === 1'b1) begin
                found = 1'b1;
            end
        end
    endtask

    task automatic check_commit(input int test, input int base);
        check_value(test, "commit pc", stim_mem[base + 1], commit_pc_o);
        check_value(test, "commit we", stim_mem[base + 2], {31'b0, commit_we_o});
        check_value(test, "commit xcpt", stim_mem[base + 5], {31'b0, commit_xcpt_o});
        // rd and data only mean something when a register is written
        if (stim_mem[base + 2][0]) begin
            check_value(test, "commit rd", stim_mem[base + 3], {27'b0, commit_rd_o});
            check_value(test, "commit data", stim_mem[base + 4], commit_data_o);
        end
    endtask

    task automatic report_test(input int test);
        $display("Test %s finished: %0d checks, %0d errors",
                 test_label(test), test_checks[test], test_errors[test]);
    endtask

    // Wishbone slave that acks 1 to 4 cycles after stb
    always @(posedge clk_i) begin
        #1;
        if (!rstn_i) begin
            wb_ack_i = 1'b0;
            bus_busy = 1'b0;
        end else if (wb_ack_i) begin
            wb_ack_i = 1'b0;
            bus_busy = 1'b0;
        end else begin
            if (bus_busy) begin
                check_value(LATENCY_TEST, "wb_stb_o held", 32'd1, {31'b0, wb_stb_o});
                check_value(LATENCY_TEST, "wb_cyc_o held", 32'd1, {31'b0, wb_cyc_o});
                check_value(LATENCY_TEST, "wb_adr_o held", req_adr, wb_adr_o);
            end else if (wb_stb_o) begin
                bus_busy  = 1'b1;
                req_adr   = wb_adr_o;
                wait_left = $unsigned($random(seed)) % 4;
                if (first_req) begin
                    check_value(LATENCY_TEST, "first fetch address", RESET_PC, wb_adr_o);
                    first_req = 1'b0;
                end
            end
            if (bus_busy) begin
                if (wait_left == 0) begin
                    wb_ack_i = 1'b1;
                    wb_dat_i = read_word(req_adr);
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin
        int   rec;
        int   rec_total;
        int   base;
        int   cur_test;
        int   total_checks;
        int   total_errors;
        logic found;
        logic done;

        seed      = 91;
        clk_i     = 1'b0;
        rstn_i    = 1'b0;
        wb_ack_i  = 1'b0;
        wb_dat_i  = '0;
        bus_busy  = 1'b0;
        first_req = 1'b1;
        req_adr   = '0;
        wait_left = 0;
        for (int i = 0; i < 6; i++) begin
            test_checks[i] = 0;
            test_errors[i] = 0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            stim_mem[i] = fill_word(i * 4);
        end
        $readmemh("verif/program_stimulus.txt", stim_mem);

        // Count records up to the end marker
        rec_total = 0;
        while (REC_BASE + (rec_total + 1) * REC_WORDS <= MEM_WORDS &&
               stim_mem[REC_BASE + rec_total * REC_WORDS + 1] != END_PC) begin
            rec_total++;
        end

        repeat (8) @(posedge clk_i);
        #1 rstn_i = 1'b1;

        rec      = 0;
        cur_test = 0;
        done     = 1'b0;
        while (!done) begin
            base = REC_BASE + rec * REC_WORDS;
            if (stim_mem[base] != cur_test) begin
                if (cur_test != 0) begin
                    report_test(cur_test);
                end
                cur_test = stim_mem[base];
            end
            if (rec >= rec_total) begin
                done = 1'b1;
            end else begin
                wait_commit(found);
                if (!found) begin
                    $display("Timeout: no commit seen within %0d cycles, expected pc %h",
                             COMMIT_TIMEOUT, stim_mem[base + 1]);
                    test_errors[cur_test]++;
                    report_test(cur_test);
                    done = 1'b1;
                end else begin
                    check_commit(cur_test, base);
                    rec++;
                end
            end
        end

        report_test(LATENCY_TEST);

        total_checks = 0;
        total_errors = 0;
        for (int i = 0; i < 6; i++) begin
            total_checks += test_checks[i];
            total_errors += test_errors[i];
        end
        $display("Totals: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
